// ==== test/tb_apb_mem.sv ====
/* APB slave memory model for the instruction fetch cache testbench
   computed words, random wait states, slave errors and a read counter */
`timescale 1ns/1ps

module tb_apb_mem (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              psel_i,
    input  logic              penable_i,
    input  icache_pkg::pc_t   paddr_i,
    output icache_pkg::inst_t prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,
    output int                read_count_o
);

    localparam icache_pkg::inst_t WORD_KEY = 32'hA5A5_0000;
    localparam icache_pkg::pc_t   ERR_BASE = 32'hF000_0000; // error region

    int waits; // wait states left in this access

    initial begin
        prdata_o     = '0;
        pready_o     = 1'b0;
        pslverr_o    = 1'b0;
        read_count_o = 0;
        waits        = 0;
    end

    // responses change on the falling edge only
    always @(negedge clk) begin
        if (!rst_n_i || !psel_i) begin
            pready_o  <= 1'b0;
            pslverr_o <= 1'b0;
        end else if (!penable_i) begin
            waits    <= $urandom % 4; // setup phase draws 0 to 3 waits
            pready_o <= 1'b0;
        end else if (waits == 0) begin
            pready_o  <= 1'b1;
            pslverr_o <= (paddr_i >= ERR_BASE);
            prdata_o  <= (paddr_i >= ERR_BASE) ? '0 : (paddr_i ^ WORD_KEY);
        end else begin
            waits <= waits - 1;
        end
    end

    // one count per completed transfer
    always @(posedge clk) begin
        if (rst_n_i && psel_i && penable_i && pready_o) begin
            read_count_o <= read_count_o + 1;
        end
    end

endmodule

// ==== test/tb_clk_gen.sv ====
/* testbench clock source, 40 ns period */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #20 clk_o = ~clk_o; // half period

endmodule

// ==== test/tb_icache_top.sv ====
/* directed testbench for the instruction fetch cache
   hits, refills, round-robin eviction, slave errors and back-pressure */
`timescale 1ns/1ps

module tb_icache_top;

    localparam int TIMEOUT = 200; // cycles per wait loop

    logic clk;
    logic rst_n_i;
    logic fetch_valid_i;
    icache_pkg::pc_t fetch_pc_i;
    logic fetch_ready_o;
    logic resp_valid_o;
    icache_pkg::inst_t resp_inst0_o;
    icache_pkg::inst_t resp_inst1_o;
    logic resp_err_o;
    logic resp_ready_i;
    logic psel;
    logic penable;
    icache_pkg::pc_t paddr;
    icache_pkg::inst_t prdata;
    logic pready;
    logic pslverr;
    logic psel_prev; // psel one cycle earlier
    int read_count;
    int errors;
    int tests_ok;
    int tests_bad;
    int seed;

    tb_clk_gen clk_gen_i (.clk_o(clk));

    tb_apb_mem apb_mem_i (
        .clk(clk), .rst_n_i(rst_n_i), .psel_i(psel), .penable_i(penable),
        .paddr_i(paddr), .prdata_o(prdata), .pready_o(pready),
        .pslverr_o(pslverr), .read_count_o(read_count)
    );

    icache_top icache_top_i (
        .clk(clk), .rst_n_i(rst_n_i),
        .fetch_valid_i(fetch_valid_i), .fetch_pc_i(fetch_pc_i),
        .fetch_ready_o(fetch_ready_o), .resp_valid_o(resp_valid_o),
        .resp_inst0_o(resp_inst0_o), .resp_inst1_o(resp_inst1_o),
        .resp_err_o(resp_err_o), .resp_ready_i(resp_ready_i),
        .psel_o(psel), .penable_o(penable), .paddr_o(paddr),
        .prdata_i(prdata), .pready_i(pready), .pslverr_i(pslverr)
    );

    // word at byte address A is A ^ A5A5_0000
    function automatic icache_pkg::inst_t expected_word(input icache_pkg::pc_t a);
        return a ^ 32'hA5A5_0000;
    endfunction

    task automatic check_inst(input string what, input icache_pkg::inst_t got,
                              input icache_pkg::inst_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_err(input string what, input apb_pkg::apb_resp_e got,
                             input apb_pkg::apb_resp_e exp);
        if (got != exp) begin
            $display("FAILED at %0t ns: %s is %s, expected %s", $time, what,
                     got.name(), exp.name());
            errors++;
        end
    endtask

    task automatic abort_run(input string msg);
        $display("stopped: %s", msg);
        $display("Test failed");
        $finish;
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d mismatches", name, errors - errs_before);
        end
    endtask

    // an access cycle only follows a setup or access cycle
    always @(negedge clk) begin
        if (rst_n_i && penable) begin
            check_count("psel_o during access", int'(psel), 1);
            check_count("psel_o before access", int'(psel_prev), 1);
        end
        psel_prev <= psel;
    end

    // one fetch started on a falling edge
    // hold is the number of cycles resp_ready_i stays low after resp_valid_o
    task automatic run_fetch(input icache_pkg::pc_t pc, input int hold,
                             output icache_pkg::inst_t inst0, output icache_pkg::inst_t inst1,
                             output apb_pkg::apb_resp_e resp, output int lat,
                             output int reads);
        int cnt;
        int reads_before;
        cnt = 0;
        while (!fetch_ready_o) begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT) abort_run("fetch_ready_o never came high");
        end
        reads_before  = read_count;
        fetch_valid_i = 1'b1;
        fetch_pc_i    = pc;
        @(posedge clk); // accepted here
        @(negedge clk);
        fetch_valid_i = 1'b0;
        lat = 0;
        while (!resp_valid_o) begin
            @(negedge clk);
            lat++;
            if (lat > TIMEOUT) abort_run("resp_valid_o never came high");
        end
        inst0 = resp_inst0_o;
        inst1 = resp_inst1_o;
        resp  = apb_pkg::apb_resp_e'(resp_err_o);
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_count("resp_valid_o while stalled", int'(resp_valid_o), 1);
            check_count("fetch_ready_o while stalled", int'(fetch_ready_o), 0);
            check_inst("held resp_inst0_o", resp_inst0_o, inst0);
            check_inst("held resp_inst1_o", resp_inst1_o, inst1);
        end
        resp_ready_i = 1'b1;
        @(negedge clk);
        resp_ready_i = 1'b0;
        check_count("resp_valid_o after handshake", int'(resp_valid_o), 0);
        reads = read_count - reads_before;
    endtask

    // fetch and check a pair that must come back without error
    task automatic fetch_good(input icache_pkg::pc_t pc, input int exp_reads, input int hold);
        icache_pkg::inst_t i0;
        icache_pkg::inst_t i1;
        apb_pkg::apb_resp_e resp;
        int lat;
        int reads;
        run_fetch(pc, hold, i0, i1, resp, lat, reads);
        check_inst("inst0", i0, expected_word(pc));
        check_inst("inst1", i1, expected_word(pc + 4));
        check_err("error flag", resp, apb_pkg::APB_OKAY);
        check_count("APB reads", reads, exp_reads);
        if (exp_reads == 0) check_count("hit latency", lat, 1);
    endtask

    task automatic cold_miss();
        int e0;
        e0 = errors;
        check_count("fetch_ready_o after reset", int'(fetch_ready_o), 1);
        check_count("resp_valid_o after reset", int'(resp_valid_o), 0);
        check_count("psel_o after reset", int'(psel), 0);
        check_count("penable_o after reset", int'(penable), 0);
        fetch_good(32'h100, 2, 0);
        end_test("cold miss", e0);
    endtask

    task automatic repeat_hit();
        int e0;
        e0 = errors;
        fetch_good(32'h100, 0, 0);
        end_test("hit", e0);
    endtask

    task automatic partial_overlap();
        int e0;
        e0 = errors;
        fetch_good(32'h104, 1, 0); // only 0x108 missing
        end_test("partial overlap", e0);
    endtask

    task automatic rr_eviction();
        int e0;
        icache_pkg::pc_t pc;
        e0 = errors;
        for (int k = 0; k < 4; k++) begin
            pc = 32'h0100_0000 + (k << 20) + ($urandom & 32'h000F_FFF8); // own 1 MB region
            fetch_good(pc, 2, 0);
        end
        fetch_good(32'h104, 2, 0);
        end_test("round-robin eviction", e0);
    endtask

    task automatic slave_error();
        int e0;
        icache_pkg::inst_t i0;
        icache_pkg::inst_t i1;
        apb_pkg::apb_resp_e resp;
        int lat;
        int reads;
        e0 = errors;
        for (int n = 0; n < 2; n++) begin
            run_fetch(32'hF000_0000, 0, i0, i1, resp, lat, reads);
            check_err("error flag", resp, apb_pkg::APB_SLVERR);
            check_inst("inst0 on error", i0, '0);
            check_inst("inst1 on error", i1, '0);
            check_count("APB reads on error", reads, 1); // nothing was cached
        end
        end_test("slave error", e0);
    endtask

    task automatic back_pressure();
        int e0;
        e0 = errors;
        fetch_good(32'h104, 0, 5);
        end_test("back-pressure", e0);
    endtask

    initial begin
        seed          = $urandom(32'h6c7e);
        rst_n_i       = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_pc_i    = '0;
        resp_ready_i  = 1'b0;
        errors        = 0;
        tests_ok      = 0;
        tests_bad     = 0;
        repeat (8) @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);
        cold_miss();
        repeat_hit();
        partial_overlap();
        rr_eviction();
        slave_error();
        back_pressure();
        $display("tests ok: %0d, tests with mismatches: %0d", tests_ok, tests_bad);
        if (errors == 0 && tests_bad == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verilog/apb_pkg.sv ====
/* bus-side types for the APB read master
   transfer phases and slave response codes */
package apb_pkg;

    // master phases of one read transfer
    typedef enum logic [1:0] {
        AS_IDLE,   // psel low
        AS_SETUP,  // psel high, penable low
        AS_ACCESS  // psel and penable high until pready
    } apb_state_e;

    // pslverr as a response code
    typedef enum logic {
        APB_OKAY   = 1'b0,
        APB_SLVERR = 1'b1
    } apb_resp_e;

endpackage

// ==== verilog/fetch_pair.sv ====
/* fetch controller: looks up pc and pc+4, refills missing words
   in order and returns the instruction pair */
`timescale 1ns/1ps
`include "icache_consts.svh"

module fetch_pair (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              fetch_valid_i,
    input  icache_pkg::pc_t   fetch_pc_i,
    output logic              fetch_ready_o,
    output logic              resp_valid_o,
    output icache_pkg::inst_t resp_inst0_o,
    output icache_pkg::inst_t resp_inst1_o,
    output logic              resp_err_o,
    input  logic              resp_ready_i,
    icache_rd_if.user         rd,
    output logic              refill_req_o,
    output icache_pkg::pc_t   refill_pc_o,
    input  logic              refill_done_i,
    input  logic              refill_err_i
);

    icache_pkg::fetch_state_e state;

    icache_pkg::pc_t   pc_q;
    icache_pkg::pc_t   pc_next;
    icache_pkg::pc_t   refill_pc_q;
    icache_pkg::inst_t inst0_q;
    icache_pkg::inst_t inst1_q;
    logic              err_q;

    assign pc_next = pc_q + `INST_BYTES;

    assign rd.rd_en0 = (state == icache_pkg::FS_LOOKUP);
    assign rd.rd_pc0 = pc_q;
    assign rd.rd_en1 = (state == icache_pkg::FS_LOOKUP);
    assign rd.rd_pc1 = pc_next;

    assign fetch_ready_o = (state == icache_pkg::FS_IDLE); // one request in flight
    assign resp_valid_o  = (state == icache_pkg::FS_RESP);
    assign resp_inst0_o  = inst0_q;
    assign resp_inst1_o  = inst1_q;
    assign resp_err_o    = err_q;

    assign refill_req_o = (state == icache_pkg::FS_REFILL);
    assign refill_pc_o  = refill_pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= icache_pkg::FS_IDLE;
            err_q <= 1'b0;
        end else begin
            case (state)
                icache_pkg::FS_IDLE: begin
                    if (fetch_valid_i) begin
                        state <= icache_pkg::FS_LOOKUP;
                    end
                end
                icache_pkg::FS_LOOKUP: begin
                    if (rd.hit0 && rd.hit1) begin
                        state <= icache_pkg::FS_RESP;
                        err_q <= 1'b0;
                    end else begin
                        state <= icache_pkg::FS_REFILL;
                    end
                end
                icache_pkg::FS_REFILL: begin
                    if (refill_done_i && refill_err_i) begin
                        state <= icache_pkg::FS_RESP;
                        err_q <= 1'b1;
                    end else if (refill_done_i) begin
                        state <= icache_pkg::FS_LOOKUP; // look the pair up again
                    end
                end
                icache_pkg::FS_RESP: begin
                    if (resp_ready_i) begin
                        state <= icache_pkg::FS_IDLE;
                    end
                end
                default: state <= icache_pkg::FS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_ready_o && fetch_valid_i) begin
            pc_q <= {fetch_pc_i[`PC_W-1:2], 2'b00}; // low bits ignored
        end
        if (state == icache_pkg::FS_LOOKUP) begin
            inst0_q     <= rd.rd_inst0;
            inst1_q     <= rd.rd_inst1;
            refill_pc_q <= rd.hit0 ? pc_next : pc_q; // word 0 first
        end
        if ((state == icache_pkg::FS_REFILL) && refill_done_i && refill_err_i) begin
            inst0_q <= '0;
            inst1_q <= '0;
        end
    end

endmodule

// ==== verilog/icache_consts.svh ====
/* instruction cache sizing constants
   shared by the packages and the cache RTL */
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

`define ICACHE_ENTRIES 8 // fully associative, one word per entry
`define ICACHE_IDX_W   3

`define PC_W           32
`define INST_W         32

`define INST_BYTES     4 // step from pc to pc+4

`endif

// ==== verilog/icache_group.sv ====
/* eight-entry fully associative instruction store
   two combinational lookup ports with write forwarding */
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_group (
    input  logic       clk,
    input  logic       rst_n_i,
    icache_rd_if.store rd,
    icache_wr_if.store wr
);

    icache_pkg::pc_t            tags  [`ICACHE_ENTRIES];
    icache_pkg::inst_t          insts [`ICACHE_ENTRIES];
    logic [`ICACHE_ENTRIES-1:0] valid; // keeps pc 0 from hitting on cleared tags

    logic [`INST_W:0] look0; // {hit, inst}
    logic [`INST_W:0] look1;

    // one lookup, forwarded write checked first, lowest index wins
    function automatic logic [`INST_W:0] lookup(input logic en,
                                                 input icache_pkg::pc_t pc);
        logic [`INST_W:0] res;
        res = '0;
        if (en) begin
            if (wr.wr_en && (wr.wr_pc == pc)) begin
                res = {1'b1, wr.wr_inst};
            end else begin
                // walk downwards so the lowest match is kept
                for (int i = `ICACHE_ENTRIES - 1; i >= 0; i--) begin
                    if (valid[i] && (tags[i] == pc)) begin
                        res = {1'b1, insts[i]};
                    end
                end
            end
        end
        return res;
    endfunction

    always_comb begin
        look0 = lookup(rd.rd_en0, rd.rd_pc0);
        look1 = lookup(rd.rd_en1, rd.rd_pc1);
    end

    assign rd.hit0     = look0[`INST_W];
    assign rd.rd_inst0 = look0[`INST_W-1:0];
    assign rd.hit1     = look1[`INST_W];
    assign rd.rd_inst1 = look1[`INST_W-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid <= '0;
            for (int i = 0; i < `ICACHE_ENTRIES; i++) begin
                tags[i]  <= '0;
                insts[i] <= '0;
            end
        end else if (wr.wr_en) begin
            tags[wr.wr_idx]  <= wr.wr_pc;
            insts[wr.wr_idx] <= wr.wr_inst;
            valid[wr.wr_idx] <= 1'b1;
        end
    end

endmodule

// ==== verilog/icache_if.sv ====
/* lookup and write interfaces between the cache group,
   the fetch controller and the refill engine */
`timescale 1ns/1ps

// two combinational lookup ports, pc and pc+4
interface icache_rd_if;
    logic              rd_en0;
    icache_pkg::pc_t   rd_pc0;
    logic              hit0;
    icache_pkg::inst_t rd_inst0;
    logic              rd_en1;
    icache_pkg::pc_t   rd_pc1;
    logic              hit1;
    icache_pkg::inst_t rd_inst1;

    modport user  (output rd_en0, rd_pc0, rd_en1, rd_pc1,
                   input  hit0, rd_inst0, hit1, rd_inst1);
    modport store (input  rd_en0, rd_pc0, rd_en1, rd_pc1,
                   output hit0, rd_inst0, hit1, rd_inst1);
endinterface

// single write port, taken on the clock edge
interface icache_wr_if;
    logic              wr_en;
    icache_pkg::idx_t  wr_idx;
    icache_pkg::pc_t   wr_pc;  // full tag
    icache_pkg::inst_t wr_inst;

    modport filler (output wr_en, wr_idx, wr_pc, wr_inst);
    modport store  (input  wr_en, wr_idx, wr_pc, wr_inst);
endinterface

// ==== verilog/icache_pkg.sv ====
/* cache-side types for the fetch front end
   addresses, instruction words, entry index and fetch FSM states */
`include "icache_consts.svh"

package icache_pkg;

    typedef logic [`PC_W-1:0]         pc_t;
    typedef logic [`INST_W-1:0]       inst_t;
    typedef logic [`ICACHE_IDX_W-1:0] idx_t; // entry / victim index

    // fetch controller
    typedef enum logic [1:0] {
        FS_IDLE,   // ready for a new fetch
        FS_LOOKUP, // both ports look up pc and pc+4
        FS_REFILL, // waiting on the refill engine
        FS_RESP    // pair held until resp_ready
    } fetch_state_e;

endpackage

// ==== verilog/icache_refill.sv ====
/* refill engine: one APB read per missed word,
   written into the entry named by a round-robin victim pointer */
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_refill (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               refill_req_i,
    input  icache_pkg::pc_t    refill_pc_i,
    output logic               refill_done_o,
    output logic               refill_err_o,
    icache_wr_if.filler        wr,
    output logic               psel_o,
    output logic               penable_o,
    output icache_pkg::pc_t    paddr_o,
    input  icache_pkg::inst_t  prdata_i,
    input  logic               pready_i,
    input  logic               pslverr_i
);

    apb_pkg::apb_state_e state;
    apb_pkg::apb_resp_e  resp;

    icache_pkg::pc_t   paddr_q;   // held for the transfer and the write
    icache_pkg::inst_t wr_inst_q;
    icache_pkg::idx_t  victim_q;
    logic              wr_en_q;
    logic              done_q;
    logic              err_q;

    assign resp = apb_pkg::apb_resp_e'(pslverr_i);

    assign psel_o    = (state != apb_pkg::AS_IDLE);
    assign penable_o = (state == apb_pkg::AS_ACCESS);
    assign paddr_o   = paddr_q;

    assign wr.wr_en   = wr_en_q;
    assign wr.wr_idx  = victim_q;
    assign wr.wr_pc   = paddr_q;
    assign wr.wr_inst = wr_inst_q;

    assign refill_done_o = done_q;
    assign refill_err_o  = err_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state    <= apb_pkg::AS_IDLE;
            victim_q <= '0;
            wr_en_q  <= 1'b0;
            done_q   <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            wr_en_q <= 1'b0; // pulses
            done_q  <= 1'b0;
            err_q   <= 1'b0;
            if (wr_en_q) begin
                if (victim_q == icache_pkg::idx_t'(`ICACHE_ENTRIES - 1)) begin
                    victim_q <= '0;
                end else begin
                    victim_q <= victim_q + 1'b1;
                end
            end
            case (state)
                apb_pkg::AS_IDLE: begin
                    // req is still high while done pulses
                    if (refill_req_i && !done_q) begin
                        state <= apb_pkg::AS_SETUP;
                    end
                end
                apb_pkg::AS_SETUP: state <= apb_pkg::AS_ACCESS;
                apb_pkg::AS_ACCESS: begin
                    if (pready_i) begin
                        state  <= apb_pkg::AS_IDLE;
                        done_q <= 1'b1;
                        if (resp == apb_pkg::APB_SLVERR) begin
                            err_q <= 1'b1; // nothing cached
                        end else begin
                            wr_en_q <= 1'b1;
                        end
                    end
                end
                default: state <= apb_pkg::AS_IDLE;
            endcase
        end
    end

    // address and read data
    always_ff @(posedge clk) begin
        if ((state == apb_pkg::AS_IDLE) && refill_req_i && !done_q) begin
            paddr_q <= refill_pc_i;
        end
        if ((state == apb_pkg::AS_ACCESS) && pready_i) begin
            wr_inst_q <= prdata_i;
        end
    end

endmodule

// ==== verilog/icache_top.sv ====
/* instruction fetch cache top level
   fetch controller, cache group and APB refill engine */
`timescale 1ns/1ps

module icache_top (
    input  logic              clk,
    input  logic              rst_n_i,
    // fetch request
    input  logic              fetch_valid_i,
    input  icache_pkg::pc_t   fetch_pc_i,
    output logic              fetch_ready_o,
    // fetch response
    output logic              resp_valid_o,
    output icache_pkg::inst_t resp_inst0_o,
    output icache_pkg::inst_t resp_inst1_o,
    output logic              resp_err_o,
    input  logic              resp_ready_i,
    // APB read master
    output logic              psel_o,
    output logic              penable_o,
    output icache_pkg::pc_t   paddr_o,
    input  icache_pkg::inst_t prdata_i,
    input  logic              pready_i,
    input  logic              pslverr_i
);

    logic            refill_req;
    icache_pkg::pc_t refill_pc;
    logic            refill_done;
    logic            refill_err;

    icache_rd_if rd_bus ();
    icache_wr_if wr_bus ();

    fetch_pair fetch_pair_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_pc_i    (fetch_pc_i),
        .fetch_ready_o (fetch_ready_o),
        .resp_valid_o  (resp_valid_o),
        .resp_inst0_o  (resp_inst0_o),
        .resp_inst1_o  (resp_inst1_o),
        .resp_err_o    (resp_err_o),
        .resp_ready_i  (resp_ready_i),
        .rd            (rd_bus.user),
        .refill_req_o  (refill_req),
        .refill_pc_o   (refill_pc),
        .refill_done_i (refill_done),
        .refill_err_i  (refill_err)
    );

    icache_group icache_group_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .rd      (rd_bus.store),
        .wr      (wr_bus.store)
    );

    icache_refill icache_refill_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .refill_req_i  (refill_req),
        .refill_pc_i   (refill_pc),
        .refill_done_o (refill_done),
        .refill_err_o  (refill_err),
        .wr            (wr_bus.filler),
        .psel_o        (psel_o),
        .penable_o     (penable_o),
        .paddr_o       (paddr_o),
        .prdata_i      (prdata_i),
        .pready_i      (pready_i),
        .pslverr_i     (pslverr_i)
    );

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/icache_pkg.sv
verilog/apb_pkg.sv
verilog/icache_if.sv
verilog/icache_group.sv
verilog/icache_refill.sv
verilog/fetch_pair.sv
verilog/icache_top.sv
test/tb_clk_gen.sv
test/tb_apb_mem.sv
test/tb_icache_top.sv
